// ==== verilog/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// bus and line geometry
`define MEM_ADDR_W      32
`define MEM_WORD_W      32
`define MEM_LINE_WORDS  4

// sets per cache, direct mapped
`define ICACHE_LINES    8
`define DCACHE_LINES    8

// uncached timer window, data side only
`define TIMER_BASE      32'h0002_0000
`define TIMER_MASK      32'hFFFF_F000

`endif

// ==== verilog/mem_pkg.sv ====
`include "mem_config.svh"

package mem_pkg;

   // word 0 sits in the low bits
   typedef logic [`MEM_LINE_WORDS-1:0][`MEM_WORD_W-1:0] line_t;

   typedef struct packed {
      logic [`MEM_ADDR_W-1:0] addr;      // line aligned, word aligned when uncached
      logic                   write;
      logic                   uncached;
      line_t                  wline;
   } line_req_t;

   typedef struct packed {
      logic                   valid;
      logic [`MEM_ADDR_W-1:0] addr;
      logic [`MEM_WORD_W-1:0] wdata;
      logic [3:0]             wstrb;
   } iomem_req_t;

   typedef enum logic [1:0] {BR_IDLE, BR_WRITE, BR_READ} bridge_state_e;

   typedef enum logic [1:0] {DC_LOOKUP, DC_EVICT, DC_REFILL, DC_RESPOND} dcache_state_e;

   typedef enum logic [1:0] {IC_LOOKUP, IC_REFILL, IC_RESPOND} icache_state_e;

   typedef enum logic {REQ_FETCH, REQ_DATA} requester_e;

endpackage

// ==== verilog/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module icache_ctrl (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   req_i,
   input  logic [`MEM_ADDR_W-1:0] addr_i,
   output logic [`MEM_WORD_W-1:0] data_o,
   output logic                   valid_o,
   output mem_pkg::line_req_t     line_req_o,
   output logic                   line_req_valid_o,
   input  logic                   line_done_i,
   input  mem_pkg::line_t         rline_i
);

   localparam int OFF_W  = $clog2(`MEM_LINE_WORDS * `MEM_WORD_W / 8);
   localparam int BYTE_W = $clog2(`MEM_WORD_W / 8);
   localparam int IDX_W  = $clog2(`ICACHE_LINES);
   localparam int TAG_W  = `MEM_ADDR_W - IDX_W - OFF_W;

   mem_pkg::icache_state_e  state_q;
   logic                    lookup_q;    // tag compare pending
   logic [`ICACHE_LINES-1:0] valid_q;
   logic [`MEM_ADDR_W-1:0]  addr_q;
   logic [`MEM_WORD_W-1:0]  data_q;
   logic [TAG_W-1:0]        tag_mem [`ICACHE_LINES];
   mem_pkg::line_t          line_mem [`ICACHE_LINES];

   logic [IDX_W-1:0]        idx;
   logic [TAG_W-1:0]        tag;
   logic [OFF_W-BYTE_W-1:0] wsel;
   logic                    hit;

   assign idx  = addr_q[OFF_W +: IDX_W];
   assign tag  = addr_q[`MEM_ADDR_W-1 -: TAG_W];
   assign wsel = addr_q[OFF_W-1:BYTE_W];
   assign hit  = valid_q[idx] && (tag_mem[idx] == tag);

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q  <= mem_pkg::IC_LOOKUP;
         lookup_q <= 1'b0;
         valid_q  <= '0;
      end else begin
         case (state_q)
            mem_pkg::IC_LOOKUP: begin
               if (lookup_q) begin
                  lookup_q <= 1'b0;
                  state_q  <= hit ? mem_pkg::IC_RESPOND : mem_pkg::IC_REFILL;
               end else if (req_i) begin
                  lookup_q <= 1'b1;
               end
            end
            mem_pkg::IC_REFILL: begin
               if (line_done_i) begin
                  valid_q[idx] <= 1'b1;
                  state_q      <= mem_pkg::IC_RESPOND;
               end
            end
            default: state_q <= mem_pkg::IC_LOOKUP;   // respond lasts one cycle
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if ((state_q == mem_pkg::IC_LOOKUP) && !lookup_q && req_i)
         addr_q <= addr_i;
      if ((state_q == mem_pkg::IC_LOOKUP) && lookup_q && hit)
         data_q <= line_mem[idx][wsel];
      if ((state_q == mem_pkg::IC_REFILL) && line_done_i) begin
         tag_mem[idx]  <= tag;
         line_mem[idx] <= rline_i;
         data_q        <= rline_i[wsel];
      end
   end

   // refills only, always cached
   assign line_req_o.addr     = {addr_q[`MEM_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
   assign line_req_o.write    = 1'b0;
   assign line_req_o.uncached = 1'b0;
   assign line_req_o.wline    = '0;
   assign line_req_valid_o    = (state_q == mem_pkg::IC_REFILL);

   assign data_o  = data_q;
   assign valid_o = (state_q == mem_pkg::IC_RESPOND);

endmodule

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module dcache_ctrl (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   req_i,
   input  logic                   we_i,
   input  logic [`MEM_ADDR_W-1:0] addr_i,
   input  logic [`MEM_WORD_W-1:0] wdata_i,
   output logic [`MEM_WORD_W-1:0] data_o,
   output logic                   valid_o,
   output mem_pkg::line_req_t     line_req_o,
   output logic                   line_req_valid_o,
   input  logic                   line_done_i,
   input  mem_pkg::line_t         rline_i
);

   localparam int OFF_W  = $clog2(`MEM_LINE_WORDS * `MEM_WORD_W / 8);
   localparam int BYTE_W = $clog2(`MEM_WORD_W / 8);
   localparam int IDX_W  = $clog2(`DCACHE_LINES);
   localparam int TAG_W  = `MEM_ADDR_W - IDX_W - OFF_W;

   mem_pkg::dcache_state_e   state_q;
   logic                     lookup_q;
   logic [`DCACHE_LINES-1:0] valid_q;
   logic [`DCACHE_LINES-1:0] dirty_q;
   logic [`MEM_ADDR_W-1:0]   addr_q;
   logic                     we_q;
   logic [`MEM_WORD_W-1:0]   wdata_q;
   logic [`MEM_WORD_W-1:0]   rdata_q;
   logic [TAG_W-1:0]         tag_mem [`DCACHE_LINES];
   mem_pkg::line_t           line_mem [`DCACHE_LINES];

   logic [IDX_W-1:0]         idx;
   logic [TAG_W-1:0]         tag;
   logic [OFF_W-BYTE_W-1:0]  wsel;
   logic                     hit;
   logic                     is_timer;
   mem_pkg::line_t           merged;

   assign idx      = addr_q[OFF_W +: IDX_W];
   assign tag      = addr_q[`MEM_ADDR_W-1 -: TAG_W];
   assign wsel     = addr_q[OFF_W-1:BYTE_W];
   assign hit      = valid_q[idx] && (tag_mem[idx] == tag);
   assign is_timer = ((addr_q & `TIMER_MASK) == `TIMER_BASE);

   // store word folded into either the resident or the incoming line
   always_comb begin
      merged = (state_q == mem_pkg::DC_REFILL) ? rline_i : line_mem[idx];
      if (we_q)
         merged[wsel] = wdata_q;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q  <= mem_pkg::DC_LOOKUP;
         lookup_q <= 1'b0;
         valid_q  <= '0;
         dirty_q  <= '0;
      end else begin
         case (state_q)
            mem_pkg::DC_LOOKUP: begin
               if (lookup_q) begin
                  lookup_q <= 1'b0;
                  if (is_timer) begin
                     // timer stores go nowhere
                     state_q <= we_q ? mem_pkg::DC_RESPOND : mem_pkg::DC_REFILL;
                  end else if (hit) begin
                     state_q <= mem_pkg::DC_RESPOND;
                     if (we_q)
                        dirty_q[idx] <= 1'b1;
                  end else if (valid_q[idx] && dirty_q[idx]) begin
                     state_q <= mem_pkg::DC_EVICT;
                  end else begin
                     state_q <= mem_pkg::DC_REFILL;
                  end
               end else if (req_i) begin
                  lookup_q <= 1'b1;
               end
            end
            mem_pkg::DC_EVICT: begin
               if (line_done_i)
                  state_q <= mem_pkg::DC_REFILL;   // level stays up for the refill
            end
            mem_pkg::DC_REFILL: begin
               if (line_done_i) begin
                  state_q <= mem_pkg::DC_RESPOND;
                  if (!is_timer) begin
                     valid_q[idx] <= 1'b1;
                     dirty_q[idx] <= we_q;
                  end
               end
            end
            default: state_q <= mem_pkg::DC_LOOKUP;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if ((state_q == mem_pkg::DC_LOOKUP) && !lookup_q && req_i) begin
         addr_q  <= addr_i;
         we_q    <= we_i;
         wdata_q <= wdata_i;
      end
      if ((state_q == mem_pkg::DC_LOOKUP) && lookup_q && hit && !is_timer) begin
         if (we_q)
            line_mem[idx] <= merged;
         else
            rdata_q <= line_mem[idx][wsel];
      end
      if ((state_q == mem_pkg::DC_REFILL) && line_done_i) begin
         if (is_timer) begin
            rdata_q <= rline_i[`MEM_LINE_WORDS-1];   // single beat lands in the top word
         end else begin
            tag_mem[idx]  <= tag;
            line_mem[idx] <= merged;
            rdata_q       <= rline_i[wsel];
         end
      end
   end

   always_comb begin
      line_req_o.write    = (state_q == mem_pkg::DC_EVICT);
      line_req_o.uncached = (state_q == mem_pkg::DC_REFILL) && is_timer;
      line_req_o.wline    = line_mem[idx];
      if (state_q == mem_pkg::DC_EVICT)
         line_req_o.addr = {tag_mem[idx], idx, {OFF_W{1'b0}}};   // victim line
      else if (is_timer)
         line_req_o.addr = {addr_q[`MEM_ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}};
      else
         line_req_o.addr = {addr_q[`MEM_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
   end

   assign line_req_valid_o = (state_q == mem_pkg::DC_EVICT) || (state_q == mem_pkg::DC_REFILL);

   assign data_o  = rdata_q;
   assign valid_o = (state_q == mem_pkg::DC_RESPOND);

endmodule

// ==== verilog/line_bridge.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module line_bridge (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   fetch_req_i,
   input  mem_pkg::line_req_t     fetch_line_i,
   input  logic                   data_req_i,
   input  mem_pkg::line_req_t     data_line_i,
   output logic                   ready_o,
   output logic                   fetch_done_o,
   output logic                   data_done_o,
   output mem_pkg::line_t         rline_o,
   output mem_pkg::iomem_req_t    iomem_o,
   input  logic                   iomem_ready_i,
   input  logic [`MEM_WORD_W-1:0] iomem_rdata_i
);

   localparam int BEAT_W = $clog2(`MEM_LINE_WORDS);
   localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`MEM_LINE_WORDS - 1);
   localparam logic [`MEM_ADDR_W-1:0] WORD_BYTES = `MEM_WORD_W / 8;

   mem_pkg::bridge_state_e state_q, state_d;
   mem_pkg::requester_e    owner_q, owner_d;
   mem_pkg::line_req_t     sel_req;
   mem_pkg::line_t         line_q, line_d;
   logic [BEAT_W-1:0]      beat_q, beat_d;
   logic                   uncached_q, uncached_d;
   logic                   ready_q, ready_d;
   logic                   valid_q, valid_d;
   logic                   fetch_done_q, fetch_done_d;
   logic                   data_done_q, data_done_d;
   logic [`MEM_ADDR_W-1:0] addr_q, addr_d;
   logic [`MEM_WORD_W-1:0] wdata_q, wdata_d;
   logic [3:0]             wstrb_q, wstrb_d;
   logic                   last_beat;
   logic                   finish;

   assign sel_req   = data_req_i ? data_line_i : fetch_line_i;   // data wins a tie
   assign last_beat = (beat_q == LAST_BEAT) || ((state_q == mem_pkg::BR_READ) && uncached_q);
   assign finish    = (state_q != mem_pkg::BR_IDLE) && iomem_ready_i && last_beat;

   always_comb begin
      state_d      = state_q;
      owner_d      = owner_q;
      line_d       = line_q;
      beat_d       = beat_q;
      uncached_d   = uncached_q;
      ready_d      = ready_q;
      valid_d      = valid_q;
      addr_d       = addr_q;
      wdata_d      = wdata_q;
      wstrb_d      = wstrb_q;
      fetch_done_d = 1'b0;
      data_done_d  = 1'b0;

      case (state_q)
         mem_pkg::BR_IDLE: begin
            valid_d = 1'b0;
            ready_d = 1'b1;
            if (ready_q && (data_req_i || fetch_req_i)) begin
               owner_d    = data_req_i ? mem_pkg::REQ_DATA : mem_pkg::REQ_FETCH;
               addr_d     = sel_req.addr;
               uncached_d = sel_req.uncached;
               beat_d     = '0;
               valid_d    = 1'b1;
               ready_d    = 1'b0;
               if (sel_req.write) begin
                  line_d  = sel_req.wline;
                  wdata_d = sel_req.wline[0];
                  wstrb_d = 4'hF;
                  state_d = mem_pkg::BR_WRITE;
               end else begin
                  wstrb_d = 4'h0;
                  state_d = mem_pkg::BR_READ;
               end
            end
         end
         mem_pkg::BR_WRITE: begin
            if (iomem_ready_i) begin
               line_d  = line_q >> `MEM_WORD_W;   // next word drops to the bottom
               beat_d  = beat_q + 1'b1;
               addr_d  = addr_q + WORD_BYTES;
               wdata_d = line_d[0];
            end
         end
         mem_pkg::BR_READ: begin
            if (iomem_ready_i) begin
               line_d = {iomem_rdata_i, line_q[`MEM_LINE_WORDS-1:1]};
               beat_d = beat_q + 1'b1;
               addr_d = addr_q + WORD_BYTES;
            end
         end
         default: state_d = mem_pkg::BR_IDLE;
      endcase

      // ready stays low through the done cycle so a held level is not taken twice
      if (finish) begin
         state_d      = mem_pkg::BR_IDLE;
         valid_d      = 1'b0;
         wstrb_d      = 4'h0;
         ready_d      = 1'b0;
         beat_d       = '0;
         fetch_done_d = (owner_q == mem_pkg::REQ_FETCH);
         data_done_d  = (owner_q == mem_pkg::REQ_DATA);
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q      <= mem_pkg::BR_IDLE;
         owner_q      <= mem_pkg::REQ_FETCH;
         beat_q       <= '0;
         ready_q      <= 1'b0;
         valid_q      <= 1'b0;
         fetch_done_q <= 1'b0;
         data_done_q  <= 1'b0;
      end else begin
         state_q      <= state_d;
         owner_q      <= owner_d;
         beat_q       <= beat_d;
         ready_q      <= ready_d;
         valid_q      <= valid_d;
         fetch_done_q <= fetch_done_d;
         data_done_q  <= data_done_d;
      end
   end

   always_ff @(posedge clk_i) begin
      line_q     <= line_d;
      uncached_q <= uncached_d;
      addr_q     <= addr_d;
      wdata_q    <= wdata_d;
      wstrb_q    <= wstrb_d;
   end

   assign iomem_o      = mem_pkg::iomem_req_t'{valid: valid_q, addr: addr_q,
                                               wdata: wdata_q, wstrb: wstrb_q};
   assign rline_o      = line_q;
   assign ready_o      = ready_q;
   assign fetch_done_o = fetch_done_q;
   assign data_done_o  = data_done_q;

endmodule

// ==== verilog/mem_subsystem_top.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_subsystem_top (
   input  logic                   clk_i,
   input  logic                   rst_i,
   // fetch port
   input  logic                   if_req_i,
   input  logic [`MEM_ADDR_W-1:0] if_addr_i,
   output logic [`MEM_WORD_W-1:0] if_data_o,
   output logic                   if_valid_o,
   // data port
   input  logic                   dm_req_i,
   input  logic                   dm_we_i,
   input  logic [`MEM_ADDR_W-1:0] dm_addr_i,
   input  logic [`MEM_WORD_W-1:0] dm_wdata_i,
   output logic [`MEM_WORD_W-1:0] dm_rdata_o,
   output logic                   dm_valid_o,
   // iomem
   output mem_pkg::iomem_req_t    iomem_o,
   input  logic                   iomem_ready_i,
   input  logic [`MEM_WORD_W-1:0] iomem_rdata_i
);

   mem_pkg::line_req_t icache_line;
   mem_pkg::line_req_t dcache_line;
   mem_pkg::line_t     rline;
   logic               icache_req;
   logic               dcache_req;
   logic               icache_done;
   logic               dcache_done;

   icache_ctrl u_icache_ctrl (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .req_i            (if_req_i),
      .addr_i           (if_addr_i),
      .data_o           (if_data_o),
      .valid_o          (if_valid_o),
      .line_req_o       (icache_line),
      .line_req_valid_o (icache_req),
      .line_done_i      (icache_done),
      .rline_i          (rline)
   );

   dcache_ctrl u_dcache_ctrl (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .req_i            (dm_req_i),
      .we_i             (dm_we_i),
      .addr_i           (dm_addr_i),
      .wdata_i          (dm_wdata_i),
      .data_o           (dm_rdata_o),
      .valid_o          (dm_valid_o),
      .line_req_o       (dcache_line),
      .line_req_valid_o (dcache_req),
      .line_done_i      (dcache_done),
      .rline_i          (rline)
   );

   line_bridge u_line_bridge (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .fetch_req_i   (icache_req),
      .fetch_line_i  (icache_line),
      .data_req_i    (dcache_req),
      .data_line_i   (dcache_line),
      .ready_o       (),
      .fetch_done_o  (icache_done),
      .data_done_o   (dcache_done),
      .rline_o       (rline),
      .iomem_o       (iomem_o),
      .iomem_ready_i (iomem_ready_i),
      .iomem_rdata_i (iomem_rdata_i)
   );

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;   // 4 ns period
   end

   initial begin
      rst_o = 1'b0;
      repeat (10) @(posedge clk_o);
      #1 rst_o = 1'b1;
   end

endmodule

// ==== dv/tb_mem_model.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_mem_model (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  mem_pkg::iomem_req_t    iomem_i,
   output logic                   ready_o,
   output logic [`MEM_WORD_W-1:0] rdata_o
);

   localparam int MEM_WORDS = 4096;
   localparam int LOG_DEPTH = 1024;

   logic [`MEM_WORD_W-1:0] mem [MEM_WORDS];
   logic [`MEM_ADDR_W-1:0] log_addr [LOG_DEPTH];   // one entry per beat
   logic [`MEM_WORD_W-1:0] timer_cnt;
   logic [31:0]            rand_state;
   int                     log_cnt;
   int                     beat_cnt;
   int                     read_beats;
   int                     wait_cnt;
   logic                   busy;

   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return rand_state;
   endfunction

   task automatic serve_beat();
      logic [11:0] idx;
      idx = iomem_i.addr[13:2];
      if (iomem_i.wstrb == 4'hF) begin
         mem[idx] = iomem_i.wdata;
      end else begin
         if ((iomem_i.addr & `TIMER_MASK) == `TIMER_BASE) begin
            rdata_o   = timer_cnt;
            timer_cnt = timer_cnt + 1;
         end else begin
            rdata_o = mem[idx];
         end
         read_beats++;
      end
      if (log_cnt < LOG_DEPTH)
         log_addr[log_cnt] = iomem_i.addr;
      log_cnt++;
      beat_cnt++;
   endtask

   initial begin
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] = 32'(i * 4) ^ 32'hA5A5_0000;
      timer_cnt  = 32'h0000_1000;
      rand_state = 32'd37357;
      log_cnt    = 0;
      beat_cnt   = 0;
      read_beats = 0;
      wait_cnt   = 0;
      busy       = 1'b0;
      ready_o    = 1'b0;
      rdata_o    = '0;
   end

   always @(posedge clk_i) begin
      #1;
      if (!rst_i) begin
         ready_o = 1'b0;
         busy    = 1'b0;
      end else if (ready_o) begin
         ready_o = 1'b0;   // single ready cycle per beat
      end else if (iomem_i.valid) begin
         if (!busy) begin
            busy     = 1'b1;
            wait_cnt = int'(next_rand() >> 16) % 4;
         end
         if (wait_cnt == 0) begin
            serve_beat();
            ready_o = 1'b1;
            busy    = 1'b0;
         end else begin
            wait_cnt--;
         end
      end
   end

endmodule

// ==== dv/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_mem_subsystem;

   localparam int TIMEOUT_CYCLES = 2000;
   localparam int REF_WORDS      = 4096;

   logic                clk;
   logic                rst;
   logic                if_req;
   logic [31:0]         if_addr;
   logic [31:0]         if_data;
   logic                if_valid;
   logic                dm_req;
   logic                dm_we;
   logic [31:0]         dm_addr;
   logic [31:0]         dm_wdata;
   logic [31:0]         dm_rdata;
   logic                dm_valid;
   mem_pkg::iomem_req_t iomem;
   logic                iomem_ready;
   logic [31:0]         iomem_rdata;

   logic [31:0]         ref_mem [REF_WORDS];
   logic [31:0]         rand_state;
   int                  err_cnt;
   int                  pass_tests;
   int                  fail_tests;
   bit                  hung;

   tb_clk_gen u_clk_gen (
      .clk_o (clk),
      .rst_o (rst)
   );

   mem_subsystem_top u_mem_subsystem_top (
      .clk_i         (clk),
      .rst_i         (rst),
      .if_req_i      (if_req),
      .if_addr_i     (if_addr),
      .if_data_o     (if_data),
      .if_valid_o    (if_valid),
      .dm_req_i      (dm_req),
      .dm_we_i       (dm_we),
      .dm_addr_i     (dm_addr),
      .dm_wdata_i    (dm_wdata),
      .dm_rdata_o    (dm_rdata),
      .dm_valid_o    (dm_valid),
      .iomem_o       (iomem),
      .iomem_ready_i (iomem_ready),
      .iomem_rdata_i (iomem_rdata)
   );

   tb_mem_model u_mem_model (
      .clk_i   (clk),
      .rst_i   (rst),
      .iomem_i (iomem),
      .ready_o (iomem_ready),
      .rdata_o (iomem_rdata)
   );

   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return rand_state;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
         err_cnt++;
      end
   endtask

   task automatic report_timeout(input string port, input logic [31:0] addr);
      $display("timeout: %s port gave no response for address %08h within %0d cycles",
               port, addr, TIMEOUT_CYCLES);
      err_cnt++;
      hung = 1'b1;
   endtask

   task automatic report_test(input string name, input int start_err);
      if (err_cnt == start_err) begin
         pass_tests++;
         $display("test %s passed", name);
      end else begin
         fail_tests++;
         $display("test %s failed", name);
      end
   endtask

   // inputs change 1 ns after the edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic fetch_word(input logic [31:0] addr, output logic [31:0] data,
                             output int cycles);
      bit got;
      got     = 1'b0;
      cycles  = 0;
      data    = 'x;
      if_req  = 1'b1;
      if_addr = addr;
      while (!got && cycles < TIMEOUT_CYCLES) begin
         next_cycle();
         cycles++;
         got = (if_valid === 1'b1);
      end
      if_req = 1'b0;
      next_cycle();   // cache is back in lookup after this
      if (got)
         data = if_data;
      else
         report_timeout("fetch", addr);
   endtask

   task automatic data_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int cycles);
      bit got;
      got      = 1'b0;
      cycles   = 0;
      rdata    = 'x;
      dm_req   = 1'b1;
      dm_we    = we;
      dm_addr  = addr;
      dm_wdata = wdata;
      while (!got && cycles < TIMEOUT_CYCLES) begin
         next_cycle();
         cycles++;
         got = (dm_valid === 1'b1);
         if (got)
            rdata = dm_rdata;
      end
      dm_req = 1'b0;
      next_cycle();   // cache is back in lookup after this
      if (!got)
         report_timeout("data", addr);
   endtask

   task automatic fetch_miss_then_hit();
      int          start_err;
      int          cycles;
      int          beats;
      logic [31:0] addr;
      logic [31:0] word;
      start_err = err_cnt;
      addr      = 32'h0000_0048;
      fetch_word(addr, word, cycles);
      check_value("fetch_miss", ref_mem[addr[13:2]], word);
      beats = u_mem_model.read_beats;
      fetch_word(addr, word, cycles);
      check_value("fetch_hit", ref_mem[addr[13:2]], word);
      check_value("fetch_hit_latency", 2, cycles);
      check_value("fetch_hit_beats", beats, u_mem_model.read_beats);
      report_test("fetch_miss_then_hit", start_err);
   endtask

   task automatic store_then_load();
      int          start_err;
      int          cycles;
      int          beats;
      logic [31:0] addr;
      logic [31:0] word;
      start_err = err_cnt;
      addr      = 32'h0000_0230;
      data_access(1'b1, addr, 32'h1234_5678, word, cycles);
      ref_mem[addr[13:2]] = 32'h1234_5678;
      beats = u_mem_model.beat_cnt;
      data_access(1'b0, addr, '0, word, cycles);
      check_value("store_load", ref_mem[addr[13:2]], word);
      check_value("store_load_latency", 2, cycles);
      check_value("store_load_beats", beats, u_mem_model.beat_cnt);
      report_test("store_then_load", start_err);
   endtask

   // a and b share set 0 of the data cache
   task automatic dirty_eviction();
      int          start_err;
      int          cycles;
      int          base;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] word;
      start_err = err_cnt;
      a         = 32'h0000_0104;
      b         = 32'h0000_0184;
      base      = int'(a[13:4]) * 4;
      data_access(1'b1, a, 32'hCAFE_0104, word, cycles);
      ref_mem[a[13:2]] = 32'hCAFE_0104;
      data_access(1'b0, b, '0, word, cycles);
      check_value("evict_load_b", ref_mem[b[13:2]], word);
      for (int k = 0; k < 4; k++)
         check_value("evict_writeback", ref_mem[base + k], u_mem_model.mem[base + k]);
      data_access(1'b0, a, '0, word, cycles);
      check_value("evict_reload_a", ref_mem[a[13:2]], word);
      report_test("dirty_eviction", start_err);
   endtask

   task automatic uncached_timer();
      int          start_err;
      int          cycles;
      logic [31:0] n;
      logic [31:0] word;
      start_err = err_cnt;
      n         = u_mem_model.timer_cnt;
      data_access(1'b0, `TIMER_BASE, '0, word, cycles);
      check_value("timer_first", n, word);
      data_access(1'b0, `TIMER_BASE + 32'h4, '0, word, cycles);
      check_value("timer_second", n + 1, word);
      report_test("uncached_timer", start_err);
   endtask

   task automatic fetch_data_contention();
      int          start_err;
      int          start_log;
      int          cycles;
      bit          got_if;
      bit          got_dm;
      logic [31:0] f_addr;
      logic [31:0] d_addr;
      logic [31:0] f_word;
      logic [31:0] d_word;
      logic [31:0] exp_line;
      start_err = err_cnt;
      start_log = u_mem_model.log_cnt;
      f_addr    = 32'h0000_0470;
      d_addr    = 32'h0000_0358;
      got_if    = 1'b0;
      got_dm    = 1'b0;
      cycles    = 0;
      if_req    = 1'b1;
      if_addr   = f_addr;
      dm_req    = 1'b1;
      dm_we     = 1'b0;
      dm_addr   = d_addr;
      while (!(got_if && got_dm) && cycles < TIMEOUT_CYCLES) begin
         next_cycle();
         cycles++;
         if (!got_if && if_valid === 1'b1) begin
            f_word = if_data;
            got_if = 1'b1;
            if_req = 1'b0;
         end
         if (!got_dm && dm_valid === 1'b1) begin
            d_word = dm_rdata;
            got_dm = 1'b1;
            dm_req = 1'b0;
         end
      end
      if_req = 1'b0;
      dm_req = 1'b0;
      next_cycle();
      if (!got_if)
         report_timeout("fetch", f_addr);
      if (!got_dm)
         report_timeout("data", d_addr);
      check_value("contention_fetch", ref_mem[f_addr[13:2]], f_word);
      check_value("contention_data", ref_mem[d_addr[13:2]], d_word);
      check_value("contention_beats", 8, u_mem_model.log_cnt - start_log);
      for (int k = 0; k < 8; k++) begin
         exp_line = (k < 4) ? (d_addr & ~32'hF) : (f_addr & ~32'hF);
         check_value("contention_order", exp_line,
                     u_mem_model.log_addr[start_log + k] & ~32'hF);
      end
      report_test("fetch_data_contention", start_err);
   endtask

   task automatic random_mix();
      int          start_err;
      int          cycles;
      logic [31:0] r;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [31:0] word;
      logic        we;
      start_err = err_cnt;
      for (int i = 0; i < 40 && !hung; i++) begin
         r     = next_rand();
         addr  = 32'h0000_0800 + {r[21:16], 2'b00};   // 64 words
         we    = r[24];
         wdata = next_rand();
         data_access(we, addr, wdata, word, cycles);
         if (we)
            ref_mem[addr[13:2]] = wdata;
         else
            check_value("random_mix", ref_mem[addr[13:2]], word);
      end
      report_test("random_mix", start_err);
   endtask

   initial begin
      int n;
      if_req     = 1'b0;
      if_addr    = '0;
      dm_req     = 1'b0;
      dm_we      = 1'b0;
      dm_addr    = '0;
      dm_wdata   = '0;
      err_cnt    = 0;
      pass_tests = 0;
      fail_tests = 0;
      hung       = 1'b0;
      rand_state = 32'd37357;
      for (int i = 0; i < REF_WORDS; i++)
         ref_mem[i] = 32'(i * 4) ^ 32'hA5A5_0000;

      n = 0;
      while (rst !== 1'b1 && n < TIMEOUT_CYCLES) begin
         @(posedge clk);
         n++;
      end
      #1;
      if (rst !== 1'b1) begin
         $display("reset was never released");
         err_cnt++;
         hung = 1'b1;
      end
      next_cycle();

      if (!hung) fetch_miss_then_hit();
      if (!hung) store_then_load();
      if (!hung) dirty_eviction();
      if (!hung) uncached_timer();
      if (!hung) fetch_data_contention();
      if (!hung) random_mix();

      $display("tests passed %0d, tests failed %0d, check errors %0d",
               pass_tests, fail_tests, err_cnt);
      if (err_cnt == 0 && fail_tests == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/mem_pkg.sv
verilog/icache_ctrl.sv
verilog/dcache_ctrl.sv
verilog/line_bridge.sv
verilog/mem_subsystem_top.sv
dv/tb_clk_gen.sv
dv/tb_mem_model.sv
dv/tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - target: any(rtl, test)
    include_dirs:
      - verilog
    files:
      - verilog/mem_pkg.sv
      - verilog/icache_ctrl.sv
      - verilog/dcache_ctrl.sv
      - verilog/line_bridge.sv
      - verilog/mem_subsystem_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_mem_model.sv
      - dv/tb_mem_subsystem.sv
